// ==== source/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    localparam int addr_w     = 32;
    localparam int index_w    = 8;    // 256 sets
    localparam int offset_w   = 4;    // 16-byte lines
    localparam int tag_w      = addr_w - index_w - offset_w;

    localparam int word_w     = 32;
    localparam int banks      = 4;    // one word per bank
    localparam int bank_sel_w = 2;

    // hit and victim logic are written for exactly two ways
    localparam int ways       = 2;

    localparam int line_w     = word_w * banks;
    localparam int strb_w     = word_w / 8;

endpackage

// ==== source/cache_types_pkg.sv ====
package cache_types_pkg;

    // one-hot main FSM
    typedef enum logic [4:0] {
        s_idle    = 5'b00001,
        s_lookup  = 5'b00010,
        s_miss    = 5'b00100,   // waiting on bridge for victim writeback
        s_replace = 5'b01000,
        s_refill  = 5'b10000
    } main_state_e;

    typedef enum logic [1:0] {
        sb_idle  = 2'b01,
        sb_write = 2'b10
    } store_state_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } cache_op_e;

    // bridge transfer size, only line is issued
    typedef enum logic [2:0] {
        xfer_byte = 3'b000,
        xfer_half = 3'b001,
        xfer_word = 3'b010,
        xfer_line = 3'b100
    } xfer_type_e;

endpackage

// ==== source/data_bank_sram.sv ====
`timescale 1ns/10ps

module data_bank_sram #(
    parameter int index_w = cache_cfg_pkg::index_w
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [index_w-1:0]                addr,
    input  logic [cache_cfg_pkg::strb_w-1:0]  we,
    input  logic [cache_cfg_pkg::word_w-1:0]  wdata,
    output logic [cache_cfg_pkg::word_w-1:0]  rdata
);
    import cache_cfg_pkg::*;

    logic [word_w-1:0] mem [2**index_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**index_w; i++) mem[i] <= '0;
            rdata <= '0;
        end else if (|we) begin
            for (int k = 0; k < strb_w; k++) begin
                if (we[k]) mem[addr][8*k +: 8] <= wdata[8*k +: 8];
            end
        end else begin
            rdata <= mem[addr];     // read reg holds during a write
        end
    end

endmodule

// ==== source/tagv_sram.sv ====
`timescale 1ns/10ps

module tagv_sram #(
    parameter int index_w = cache_cfg_pkg::index_w
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [index_w-1:0]            addr,
    input  logic                          we,
    input  logic [cache_cfg_pkg::tag_w:0] wdata,   // tag above, valid in bit 0
    output logic [cache_cfg_pkg::tag_w:0] rdata
);
    import cache_cfg_pkg::*;

    logic [tag_w:0] mem [2**index_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**index_w; i++) mem[i][0] <= 1'b0;
            rdata <= '0;
        end else if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== source/store_buffer.sv ====
`timescale 1ns/10ps

module store_buffer #(
    parameter int index_w = cache_cfg_pkg::index_w
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 sb_load,
    input  logic [index_w-1:0]                   req_index,
    input  logic [cache_cfg_pkg::offset_w-1:0]   req_offset,
    input  logic [cache_cfg_pkg::strb_w-1:0]     req_wstrb,
    input  logic [cache_cfg_pkg::word_w-1:0]     req_wdata,
    input  logic                                 hit_way,
    output logic                                 sb_busy,
    output logic                                 sb_way,
    output logic [cache_cfg_pkg::bank_sel_w-1:0] sb_bank,
    output logic [index_w-1:0]                   sb_index,
    output logic [cache_cfg_pkg::strb_w-1:0]     sb_wstrb,
    output logic [cache_cfg_pkg::word_w-1:0]     sb_wdata
);
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    store_state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sb_idle;
        end else begin
            case (state)
                sb_idle:  if (sb_load) state <= sb_write;
                sb_write: if (!sb_load) state <= sb_idle;   // stays busy on back-to-back hits
                default:  state <= sb_idle;
            endcase
        end
    end

    // captured store word, written during the busy cycle
    always_ff @(posedge clk) begin
        if (sb_load) begin
            sb_way   <= hit_way;
            sb_bank  <= req_offset[offset_w-1 -: bank_sel_w];
            sb_index <= req_index;
            sb_wstrb <= req_wstrb;
            sb_wdata <= req_wdata;
        end
    end

    assign sb_busy = (state == sb_write);

endmodule

// ==== source/victim_select.sv ====
`timescale 1ns/10ps

module victim_select #(
    parameter int index_w = cache_cfg_pkg::index_w
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [index_w-1:0]              req_index,
    input  logic [cache_cfg_pkg::ways-1:0]  valid_bits,
    input  logic                            sb_busy,
    input  logic [index_w-1:0]              sb_index,
    input  logic                            sb_way,
    input  logic                            refill_done,
    input  logic                            refill_way,
    input  logic                            refill_dirty,
    output logic                            replace_way,
    output logic                            replace_dirty
);
    import cache_cfg_pkg::*;

    logic [ways-1:0] dirty [2**index_w];
    logic [ways-1:0] way_dirty;
    logic [7:0]      lfsr;

    // refill and store-buffer writes never land in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**index_w; i++) dirty[i] <= '0;
        end else if (refill_done) begin
            dirty[req_index][refill_way] <= refill_dirty;   // new line clean unless store miss
        end else if (sb_busy) begin
            dirty[sb_index][sb_way] <= 1'b1;
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 8'hA5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // include a same-set store still in flight
    assign way_dirty = dirty[req_index] |
                       ((sb_busy && sb_index == req_index) ? (ways'(1) << sb_way) : '0);

    // lowest invalid way first
    assign replace_way = !valid_bits[0] ? 1'b0 :
                         !valid_bits[1] ? 1'b1 : lfsr[0];

    assign replace_dirty = valid_bits[replace_way] && way_dirty[replace_way];

endmodule

// ==== source/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl #(
    parameter int index_w = cache_cfg_pkg::index_w
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 valid,
    input  logic                                 op,
    input  logic [index_w-1:0]                   index,
    input  logic [cache_cfg_pkg::tag_w-1:0]      tag,
    input  logic [cache_cfg_pkg::offset_w-1:0]   offset,
    input  logic [cache_cfg_pkg::strb_w-1:0]     wstrb,
    input  logic [cache_cfg_pkg::word_w-1:0]     wdata,
    output logic                                 addr_ok,
    output logic                                 data_ok,
    output logic [cache_cfg_pkg::word_w-1:0]     rdata,
    output logic                                 rd_req,
    output logic [2:0]                           rd_type,
    output logic [cache_cfg_pkg::addr_w-1:0]     rd_addr,
    input  logic                                 rd_rdy,
    input  logic                                 ret_valid,
    input  logic                                 ret_last,
    input  logic [cache_cfg_pkg::word_w-1:0]     ret_data,
    output logic                                 wr_req,
    output logic [2:0]                           wr_type,
    output logic [cache_cfg_pkg::addr_w-1:0]     wr_addr,
    output logic [cache_cfg_pkg::strb_w-1:0]     wr_wstrb,
    output logic [cache_cfg_pkg::line_w-1:0]     wr_data,
    input  logic                                 wr_rdy,
    input  logic [cache_cfg_pkg::tag_w:0]        tagv_rdata [cache_cfg_pkg::ways],
    input  logic [cache_cfg_pkg::word_w-1:0]     bank_rdata [cache_cfg_pkg::ways][cache_cfg_pkg::banks],
    output logic [index_w-1:0]                   tagv_addr,
    output logic [cache_cfg_pkg::ways-1:0]       tagv_we,
    output logic [cache_cfg_pkg::tag_w:0]        tagv_wdata,
    output logic [index_w-1:0]                   bank_addr  [cache_cfg_pkg::ways][cache_cfg_pkg::banks],
    output logic [cache_cfg_pkg::strb_w-1:0]     bank_we    [cache_cfg_pkg::ways][cache_cfg_pkg::banks],
    output logic [cache_cfg_pkg::word_w-1:0]     bank_wdata [cache_cfg_pkg::ways][cache_cfg_pkg::banks],
    output logic                                 sb_load,
    output logic [index_w-1:0]                   req_index,
    output logic [cache_cfg_pkg::offset_w-1:0]   req_offset,
    output logic [cache_cfg_pkg::strb_w-1:0]     req_wstrb,
    output logic [cache_cfg_pkg::word_w-1:0]     req_wdata,
    output logic                                 hit_way,
    input  logic                                 sb_busy,
    input  logic                                 sb_way,
    input  logic [cache_cfg_pkg::bank_sel_w-1:0] sb_bank,
    input  logic [index_w-1:0]                   sb_index,
    input  logic [cache_cfg_pkg::strb_w-1:0]     sb_wstrb,
    input  logic [cache_cfg_pkg::word_w-1:0]     sb_wdata,
    input  logic                                 replace_way,
    input  logic                                 replace_dirty,
    output logic                                 refill_done,
    output logic                                 refill_way,
    output logic                                 refill_dirty
);
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    main_state_e            state;
    cache_op_e              req_op;
    logic [tag_w-1:0]       req_tag;
    logic [bank_sel_w-1:0]  req_bank;
    logic                   miss_way;
    logic [bank_sel_w-1:0]  ret_cnt;    // beat counter in refill
    logic [ways-1:0]        way_hit;
    logic                   cache_hit;
    logic [index_w-1:0]     lookup_index;
    logic [word_w-1:0]      merged_word;
    logic [word_w-1:0]      refill_data;

    // a store-buffer write only blocks a request to the same bank
    assign addr_ok = (state == s_idle) &&
                     !(sb_busy && sb_bank == offset[offset_w-1 -: bank_sel_w]);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= s_idle;
            wr_req  <= 1'b0;
            ret_cnt <= '0;
        end else begin
            case (state)
                s_idle: if (valid && addr_ok) state <= s_lookup;
                s_lookup: begin
                    if (cache_hit) state <= s_idle;
                    else if (replace_dirty) state <= s_miss;
                    else state <= s_replace;
                end
                s_miss: begin
                    if (wr_rdy) begin
                        state  <= s_replace;
                        wr_req <= 1'b1;
                    end
                end
                s_replace: begin
                    wr_req <= 1'b0;    // single-cycle pulse
                    if (rd_rdy) begin
                        state   <= s_refill;
                        ret_cnt <= '0;
                    end
                end
                s_refill: begin
                    if (ret_valid) ret_cnt <= ret_cnt + 1'b1;
                    if (ret_valid && ret_last) state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // request and miss buffers
    always_ff @(posedge clk) begin
        if (state == s_idle && valid && addr_ok) begin
            req_op     <= cache_op_e'(op);
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
        if (state == s_lookup) miss_way <= replace_way;
    end

    assign req_bank = req_offset[offset_w-1 -: bank_sel_w];

    for (genvar w = 0; w < ways; w++) begin : g_hit
        assign way_hit[w] = tagv_rdata[w][0] && (tagv_rdata[w][tag_w:1] == req_tag);
        assign tagv_we[w] = refill_done && (miss_way == w);
    end
    assign cache_hit = |way_hit;
    assign hit_way   = way_hit[1];
    assign sb_load   = (state == s_lookup) && cache_hit && (req_op == op_store);

    // stores always complete at lookup, load misses on their beat
    assign data_ok = (state == s_lookup && (cache_hit || req_op == op_store)) ||
                     (state == s_refill && req_op == op_load && ret_valid &&
                      ret_cnt == req_bank);
    assign rdata = (state == s_lookup) ? bank_rdata[hit_way][req_bank] : ret_data;

    // bridge requests
    assign rd_req   = (state == s_replace);
    assign rd_type  = xfer_line;
    assign rd_addr  = addr_w'({req_tag, req_index, {offset_w{1'b0}}});
    assign wr_type  = xfer_line;
    assign wr_addr  = addr_w'({tagv_rdata[miss_way][tag_w:1], req_index, {offset_w{1'b0}}});
    assign wr_wstrb = '1;

    // victim line, ram re-reads req_index while in miss
    for (genvar b = 0; b < banks; b++) begin : g_victim
        assign wr_data[b*word_w +: word_w] = bank_rdata[miss_way][b];
    end

    // store miss merges its bytes into the returning beat
    always_comb begin
        for (int k = 0; k < strb_w; k++) begin
            merged_word[8*k +: 8] = req_wstrb[k] ? req_wdata[8*k +: 8] : ret_data[8*k +: 8];
        end
    end
    assign refill_data = (req_op == op_store && ret_cnt == req_bank) ? merged_word : ret_data;

    assign refill_done  = (state == s_refill) && ret_valid && ret_last;
    assign refill_way   = miss_way;
    assign refill_dirty = (req_op == op_store);

    assign lookup_index = (state == s_idle) ? index : req_index;
    assign tagv_addr    = lookup_index;
    assign tagv_wdata   = {req_tag, 1'b1};

    // per-bank port mux, store buffer and refill never overlap
    for (genvar w = 0; w < ways; w++) begin : g_way
        for (genvar b = 0; b < banks; b++) begin : g_bank
            logic sb_match;
            logic refill_match;

            assign sb_match     = sb_busy && (sb_way == w) && (sb_bank == b);
            assign refill_match = (state == s_refill) && ret_valid &&
                                  (miss_way == w) && (ret_cnt == b);
            assign bank_addr[w][b]  = sb_match ? sb_index : lookup_index;
            assign bank_we[w][b]    = sb_match ? sb_wstrb : {strb_w{refill_match}};
            assign bank_wdata[w][b] = sb_match ? sb_wdata : refill_data;
        end
    end

endmodule

// ==== source/cache_top.sv ====
`timescale 1ns/10ps

module cache_top #(
    parameter int index_w = cache_cfg_pkg::index_w
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                valid,
    input  logic                                op,
    input  logic [index_w-1:0]                  index,
    input  logic [cache_cfg_pkg::tag_w-1:0]     tag,
    input  logic [cache_cfg_pkg::offset_w-1:0]  offset,
    input  logic [cache_cfg_pkg::strb_w-1:0]    wstrb,
    input  logic [cache_cfg_pkg::word_w-1:0]    wdata,
    output logic                                addr_ok,
    output logic                                data_ok,
    output logic [cache_cfg_pkg::word_w-1:0]    rdata,
    output logic                                rd_req,
    output logic [2:0]                          rd_type,
    output logic [cache_cfg_pkg::addr_w-1:0]    rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  logic [cache_cfg_pkg::word_w-1:0]    ret_data,
    output logic                                wr_req,
    output logic [2:0]                          wr_type,
    output logic [cache_cfg_pkg::addr_w-1:0]    wr_addr,
    output logic [cache_cfg_pkg::strb_w-1:0]    wr_wstrb,
    output logic [cache_cfg_pkg::line_w-1:0]    wr_data,
    input  logic                                wr_rdy
);
    import cache_cfg_pkg::*;

    // ram side
    logic [tag_w:0]         tagv_rdata [ways];
    logic [word_w-1:0]      bank_rdata [ways][banks];
    logic [index_w-1:0]     tagv_addr;
    logic [ways-1:0]        tagv_we;
    logic [tag_w:0]         tagv_wdata;
    logic [index_w-1:0]     bank_addr  [ways][banks];
    logic [strb_w-1:0]      bank_we    [ways][banks];
    logic [word_w-1:0]      bank_wdata [ways][banks];

    // store buffer handoff
    logic                   sb_load;
    logic [index_w-1:0]     req_index;
    logic [offset_w-1:0]    req_offset;
    logic [strb_w-1:0]      req_wstrb;
    logic [word_w-1:0]      req_wdata;
    logic                   hit_way;
    logic                   sb_busy;
    logic                   sb_way;
    logic [bank_sel_w-1:0]  sb_bank;
    logic [index_w-1:0]     sb_index;
    logic [strb_w-1:0]      sb_wstrb;
    logic [word_w-1:0]      sb_wdata;

    // replacement
    logic                   replace_way;
    logic                   replace_dirty;
    logic                   refill_done;
    logic                   refill_way;
    logic                   refill_dirty;

    cache_ctrl #(.index_w(index_w)) cache_ctrl_inst (.*);

    store_buffer #(.index_w(index_w)) store_buffer_inst (.*);

    victim_select #(.index_w(index_w)) victim_select_inst (
        .valid_bits ({tagv_rdata[1][0], tagv_rdata[0][0]}),
        .*
    );

    for (genvar w = 0; w < ways; w++) begin : g_way
        tagv_sram #(.index_w(index_w)) tagv_sram_inst (
            .clk   (clk),
            .reset (reset),
            .addr  (tagv_addr),
            .we    (tagv_we[w]),
            .wdata (tagv_wdata),
            .rdata (tagv_rdata[w])
        );

        for (genvar b = 0; b < banks; b++) begin : g_bank
            data_bank_sram #(.index_w(index_w)) data_bank_sram_inst (
                .clk   (clk),
                .reset (reset),
                .addr  (bank_addr[w][b]),
                .we    (bank_we[w][b]),
                .wdata (bank_wdata[w][b]),
                .rdata (bank_rdata[w][b])
            );
        end
    end

endmodule

// ==== dv/cache_asserts.sv ====
`timescale 1ns/10ps

module cache_asserts (
    input logic clk,
    input logic reset,
    input logic data_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req
);

    int fail_count = 0;    // failed properties so far

    // outputs stay quiet out of a reset cycle
    a_reset_quiet: assert property (@(posedge clk) reset |=> !data_ok && !rd_req && !wr_req)
        else begin
            fail_count++;
            $error("data_ok, rd_req or wr_req high right after a reset cycle");
        end

    a_wr_pulse: assert property (@(posedge clk) disable iff (reset) wr_req |=> !wr_req)
        else begin
            fail_count++;
            $error("wr_req held high for more than one cycle");
        end

    // read request holds until the bridge takes it
    a_rd_hold: assert property (@(posedge clk) disable iff (reset) rd_req && !rd_rdy |=> rd_req)
        else begin
            fail_count++;
            $error("rd_req dropped before rd_rdy was seen");
        end

    a_data_ok_pulse: assert property (@(posedge clk) disable iff (reset) data_ok |=> !data_ok)
        else begin
            fail_count++;
            $error("data_ok high for two cycles in a row");
        end

endmodule

bind cache_top cache_asserts cache_asserts_inst (.*);

// ==== dv/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb;
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    typedef struct packed {
        cache_op_e   op;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        bit          exp_hit;   // load must hit, otherwise latency not checked
        int          exp_wb;    // writebacks so far, -1 when the victim is random
    } row_t;

    localparam int n_rows = 20;
    localparam int timeout_cycles = 200;

    // tag 31:12, set 11:4, byte 3:0
    row_t stim [n_rows] = '{
        '{op_load,  32'h0001_0124, 4'b0000, 32'h0000_0000, 1'b0, 0},  // miss, fresh line
        '{op_load,  32'h0001_0124, 4'b0000, 32'h0000_0000, 1'b1, 0},  // same word as hit
        '{op_store, 32'h0001_0128, 4'b0110, 32'haabb_ccdd, 1'b1, 0},  // partial store hit
        '{op_load,  32'h0001_012c, 4'b0000, 32'h0000_0000, 1'b1, 0},  // other bank under sb write
        '{op_load,  32'h0001_0128, 4'b0000, 32'h0000_0000, 1'b1, 0},
        '{op_store, 32'h0002_0344, 4'b1001, 32'h1122_3344, 1'b0, 0},  // store miss
        '{op_load,  32'h0002_0344, 4'b0000, 32'h0000_0000, 1'b1, 0},
        '{op_load,  32'h0003_0560, 4'b0000, 32'h0000_0000, 1'b0, 0},  // set 0x56, way 0
        '{op_load,  32'h0004_0564, 4'b0000, 32'h0000_0000, 1'b0, 0},  // set 0x56, way 1
        '{op_store, 32'h0003_0568, 4'b1111, 32'hdead_beef, 1'b1, 0},
        '{op_store, 32'h0004_056c, 4'b0011, 32'h0000_5aa5, 1'b1, 0},
        '{op_load,  32'h0005_0560, 4'b0000, 32'h0000_0000, 1'b0, 1},  // third tag, dirty victim
        '{op_store, 32'h0006_0120, 4'b1111, 32'h0bad_f00d, 1'b0, 1},  // fills free way of 0x12
        '{op_load,  32'h0007_0124, 4'b0000, 32'h0000_0000, 1'b0, 2},  // both ways dirty
        '{op_load,  32'h0003_0568, 4'b0000, 32'h0000_0000, 1'b0, -1},
        '{op_load,  32'h0004_056c, 4'b0000, 32'h0000_0000, 1'b0, -1},
        '{op_store, 32'h0005_0564, 4'b1100, 32'hcafe_0000, 1'b0, -1},
        '{op_load,  32'h0003_0560, 4'b0000, 32'h0000_0000, 1'b0, -1},
        '{op_load,  32'h0005_0564, 4'b0000, 32'h0000_0000, 1'b0, -1},
        '{op_load,  32'h0001_0128, 4'b0000, 32'h0000_0000, 1'b0, -1}
    };

    logic                clk;
    logic                reset;
    logic                valid;
    logic                op;
    logic [index_w-1:0]  index;
    logic [tag_w-1:0]    tag;
    logic [offset_w-1:0] offset;
    logic [strb_w-1:0]   wstrb;
    logic [word_w-1:0]   wdata;
    logic                addr_ok;
    logic                data_ok;
    logic [word_w-1:0]   rdata;
    logic                rd_req;
    logic [2:0]          rd_type;
    logic [addr_w-1:0]   rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [word_w-1:0]   ret_data;
    logic                wr_req;
    logic [2:0]          wr_type;
    logic [addr_w-1:0]   wr_addr;
    logic [strb_w-1:0]   wr_wstrb;
    logic [line_w-1:0]   wr_data;
    logic                wr_rdy;

    logic [line_w-1:0] shadow  [logic [addr_w-1:0]];   // what the CPU should see
    logic [line_w-1:0] backing [logic [addr_w-1:0]];   // what the bridge holds
    integer seed = 34;
    int wb_count = 0;

    cache_top #(.index_w(index_w)) cache_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [line_w-1:0] fill_line(input logic [addr_w-1:0] line_addr);
        logic [line_w-1:0] words;
        for (int b = 0; b < banks; b++) begin
            words[b*word_w +: word_w] = (line_addr + addr_w'(4 * b)) ^ 32'h5ac3_9e17;
        end
        return words;
    endfunction

    function automatic void touch_line(input logic [addr_w-1:0] line_addr);
        if (!shadow.exists(line_addr)) begin
            shadow[line_addr]  = fill_line(line_addr);
            backing[line_addr] = fill_line(line_addr);
        end
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [line_w-1:0] got, input logic [line_w-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // a failed bound assertion ends the run at once
    always @(negedge clk) begin
        if (cache_top_inst.cache_asserts_inst.fail_count != 0) begin
            $display("A bound assertion on cache_top failed");
            abort_run();
        end
    end

    // bridge read side, random ready delay and beat gaps
    initial begin : read_side
        logic [addr_w-1:0] la;
        int gap;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        forever begin
            @(posedge clk);
            if (!reset && rd_req) begin
                la = rd_addr;
                check_value(rd_type, xfer_line, "rd_type");
                check_value(la[offset_w-1:0], 0, "rd_addr alignment");
                touch_line(la);
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(posedge clk);
                @(negedge clk);
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int b = 0; b < banks; b++) begin
                    repeat ($unsigned($random(seed)) % 3) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last = (b == banks - 1);
                    ret_data = backing[la][b*word_w +: word_w];
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last = 1'b0;
                end
            end
        end
    end

    // bridge write side, ready comes and goes at random
    initial begin : write_side
        logic [addr_w-1:0] la;
        wr_rdy = 1'b0;
        forever begin
            @(negedge clk);
            wr_rdy = ($random(seed) % 3) == 0;
            @(posedge clk);
            if (!reset && wr_req) begin
                la = wr_addr;
                check_value(wr_type, xfer_line, "wr_type");
                check_value(wr_wstrb, 4'hf, "wr_wstrb");
                if (!shadow.exists(la)) begin
                    $display("Writeback to line %0h, which was never requested", la);
                    abort_run();
                end
                check_value(wr_data, shadow[la], $sformatf("writeback of line %0h", la));
                backing[la] = wr_data;
                wb_count++;
            end
        end
    end

    task automatic run_row(input row_t r);
        logic [addr_w-1:0] la;
        logic [line_w-1:0] words;
        int bank;
        int waited;
        int k;
        la = {r.addr[addr_w-1:offset_w], {offset_w{1'b0}}};
        bank = r.addr[offset_w-1:2];
        touch_line(la);
        @(negedge clk);
        valid = 1'b1;
        op = r.op;
        {tag, index, offset} = r.addr;
        wstrb = r.wstrb;
        wdata = r.wdata;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                $display("Timeout: addr_ok never came for address %0h", r.addr);
                abort_run();
            end
        end while (!addr_ok);
        @(negedge clk);
        valid = 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                $display("Timeout: data_ok never came for address %0h", r.addr);
                abort_run();
            end
        end while (!data_ok);
        words = shadow[la];
        if (r.op == op_load) begin
            if (r.exp_hit) begin
                check_value(waited, 1, "load hit latency");
            end
            check_value(rdata, words[bank*word_w +: word_w], $sformatf("load at %0h", r.addr));
        end else begin
            check_value(waited, 1, "store data_ok latency");
            for (k = 0; k < strb_w; k++) begin
                if (r.wstrb[k]) words[bank*word_w + 8*k +: 8] = r.wdata[8*k +: 8];
            end
            shadow[la] = words;
        end
    endtask

    initial begin
        int waited;
        reset = 1'b1;
        valid = 1'b0;
        op = 1'b0;
        index = '0;
        tag = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            run_row(stim[i]);
            if (stim[i].exp_wb != -1) begin
                check_value(wb_count, stim[i].exp_wb, "writeback count");
            end
        end

        // let the last miss finish
        waited = 0;
        while (!addr_ok) begin
            @(posedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                $display("Timeout: cache never went back to idle after the last request");
                abort_run();
            end
        end
        @(negedge clk);

        if (cache_top_inst.cache_asserts_inst.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("A bound assertion on cache_top failed");
            abort_run();
        end
    end

endmodule

// ==== tb.f ====
source/cache_cfg_pkg.sv
source/cache_types_pkg.sv
source/data_bank_sram.sv
source/tagv_sram.sv
source/store_buffer.sv
source/victim_select.sv
source/cache_ctrl.sv
source/cache_top.sv
dv/cache_asserts.sv
dv/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  - files:
      - source/cache_cfg_pkg.sv
      - source/cache_types_pkg.sv
      - source/data_bank_sram.sv
      - source/tagv_sram.sv
      - source/store_buffer.sv
      - source/victim_select.sv
      - source/cache_ctrl.sv
      - source/cache_top.sv
  - target: test
    files:
      - dv/cache_asserts.sv
      - dv/cache_tb.sv
